//--- Bender.yml
package:
  name: fxp_pipe

sources:
  - files:
      - logic/fxp_pipe_pkg.sv
      - logic/fxp_pipe_retime.sv
      - logic/fxp_pipe_decode.sv
      - logic/fxp_pipe_mul_add.sv
      - logic/fxp_pipe_round.sv
      - logic/fxp_pipe_fma.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/fxp_pipe_tb.sv

//--- logic/fxp_pipe_decode.sv
`timescale 1ns/10ps

module fxp_pipe_decode
  import fxp_pipe_pkg::*;
#(
  parameter int data_width_p = 32,
  parameter int frac_width_p = 16
)
(
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    v_i,
  input  logic                    poison_i,
  input  fu_op_e                  fu_op_i,
  input  rm_e                     rm_i,
  input  rm_e                     frm_dyn_i,
  input  logic                    narrow_i,
  input  logic                    word_i,
  input  logic [data_width_p-1:0] rs1_i,
  input  logic [data_width_p-1:0] rs2_i,
  input  logic [data_width_p-1:0] rs3_i,
  output logic                    v_o,
  output logic                    is_imul_o,
  output logic                    narrow_o,
  output logic                    word_o,
  output rm_e                     rm_o,
  output mac_op_t                 mac_op_o,
  output logic [data_width_p-1:0] a_o,
  output logic [data_width_p-1:0] b_o,
  output logic [data_width_p-1:0] c_o
);

  // the value 1.0 in the fixed point format, used as b for fadd and fsub
  localparam logic [data_width_p-1:0] fxp_one_lp =
    {{(data_width_p-1){1'b0}}, 1'b1} << frac_width_p;

  rm_e                     rm_sel;
  rm_e                     rm_res;
  mac_op_t                 mac_op;
  logic [data_width_p-1:0] a_sel;
  logic [data_width_p-1:0] b_sel;
  logic [data_width_p-1:0] c_sel;

  // dyn takes the mode from the frm register, and any code above rmm acts as rtz
  always_comb
  begin
    rm_sel = (rm_i == dyn) ? frm_dyn_i : rm_i;
    rm_res = (rm_sel > rmm) ? rtz : rm_sel;
  end

  always_comb
  begin
    mac_op = 2'b00;
    a_sel  = rs1_i;
    b_sel  = rs2_i;
    c_sel  = rs3_i;
    case (fu_op_i)
      fadd, fsub:
      begin
        mac_op = (fu_op_i == fsub) ? 2'b01 : 2'b00;
        b_sel  = fxp_one_lp;
        c_sel  = rs2_i;
      end
      fmul:
      begin
        c_sel = '0;
      end
      fmsub:  mac_op = 2'b01;
      fnmsub: mac_op = 2'b10;
      fnmadd: mac_op = 2'b11;
      imul:
      begin
        // raw integer operands, the addend is not used
        c_sel = '0;
      end
      default: mac_op = 2'b00;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      v_o <= 1'b0;
    else
      v_o <= v_i & ~poison_i;
  end

  always_ff @(posedge clk_i)
  begin
    is_imul_o <= (fu_op_i == imul);
    narrow_o  <= narrow_i;
    word_o    <= word_i;
    rm_o      <= rm_res;
    mac_op_o  <= mac_op;
    a_o       <= a_sel;
    b_o       <= b_sel;
    c_o       <= c_sel;
  end

endmodule

//--- logic/fxp_pipe_fma.sv
`timescale 1ns/10ps

module fxp_pipe_fma
  import fxp_pipe_pkg::*;
#(
  parameter int data_width_p   = 32,
  parameter int frac_width_p   = 16,
  parameter int fma_latency_p  = 4,
  parameter int imul_latency_p = 3
)
(
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    v_i,
  input  logic                    poison_i,
  input  fu_op_e                  fu_op_i,
  input  rm_e                     rm_i,
  input  rm_e                     frm_dyn_i,
  input  logic                    narrow_i,
  input  logic                    word_i,
  input  logic [data_width_p-1:0] rs1_i,
  input  logic [data_width_p-1:0] rs2_i,
  input  logic [data_width_p-1:0] rs3_i,
  output logic                    fma_v_o,
  output logic [data_width_p-1:0] fma_data_o,
  output fflags_t                 fma_fflags_o,
  output logic                    imul_v_o,
  output logic [data_width_p-1:0] imul_data_o
);

  // decode and mul_add each hold one register stage
  localparam int fma_stages_lp  = fma_latency_p - 2;
  localparam int imul_stages_lp = imul_latency_p - 2;

  logic                      dec_v, dec_is_imul, dec_narrow, dec_word;
  rm_e                       dec_rm;
  mac_op_t                   dec_mac_op;
  logic [data_width_p-1:0]   dec_a, dec_b, dec_c;

  logic                      raw_v, raw_is_imul, raw_narrow, raw_word;
  rm_e                       raw_rm;
  logic [2*data_width_p+1:0] raw_sum;
  logic [data_width_p-1:0]   raw_prod_lo;

  logic                      fma_v, imul_v;
  logic [data_width_p-1:0]   fma_data, imul_data;
  fflags_t                   fma_fflags;

  fxp_pipe_decode #(.data_width_p(data_width_p), .frac_width_p(frac_width_p)) decode
  (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .v_i(v_i), .poison_i(poison_i),
    .fu_op_i(fu_op_i), .rm_i(rm_i), .frm_dyn_i(frm_dyn_i), .narrow_i(narrow_i),
    .word_i(word_i), .rs1_i(rs1_i), .rs2_i(rs2_i), .rs3_i(rs3_i),
    .v_o(dec_v), .is_imul_o(dec_is_imul), .narrow_o(dec_narrow), .word_o(dec_word),
    .rm_o(dec_rm), .mac_op_o(dec_mac_op), .a_o(dec_a), .b_o(dec_b), .c_o(dec_c)
  );

  fxp_pipe_mul_add #(.data_width_p(data_width_p), .frac_width_p(frac_width_p)) mul_add
  (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .v_i(dec_v), .is_imul_i(dec_is_imul),
    .narrow_i(dec_narrow), .word_i(dec_word), .rm_i(dec_rm), .mac_op_i(dec_mac_op),
    .a_i(dec_a), .b_i(dec_b), .c_i(dec_c),
    .v_o(raw_v), .is_imul_o(raw_is_imul), .narrow_o(raw_narrow), .word_o(raw_word),
    .rm_o(raw_rm), .sum_o(raw_sum), .prod_lo_o(raw_prod_lo)
  );

  fxp_pipe_round #(.data_width_p(data_width_p), .frac_width_p(frac_width_p)) round
  (
    .v_i(raw_v), .is_imul_i(raw_is_imul), .narrow_i(raw_narrow), .word_i(raw_word),
    .rm_i(raw_rm), .sum_i(raw_sum), .prod_lo_i(raw_prod_lo),
    .fma_v_o(fma_v), .fma_data_o(fma_data), .fma_fflags_o(fma_fflags),
    .imul_v_o(imul_v), .imul_data_o(imul_data)
  );

  fxp_pipe_retime #(.width_p(data_width_p+2), .stages_p(fma_stages_lp)) fma_retime
  (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .v_i(fma_v), .data_i({fma_fflags, fma_data}),
    .v_o(fma_v_o), .data_o({fma_fflags_o, fma_data_o})
  );

  fxp_pipe_retime #(.width_p(data_width_p), .stages_p(imul_stages_lp)) imul_retime
  (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .v_i(imul_v), .data_i(imul_data),
    .v_o(imul_v_o), .data_o(imul_data_o)
  );

endmodule

//--- logic/fxp_pipe_mul_add.sv
`timescale 1ns/10ps

module fxp_pipe_mul_add
  import fxp_pipe_pkg::*;
#(
  parameter int data_width_p = 32,
  parameter int frac_width_p = 16
)
(
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        v_i,
  input  logic                        is_imul_i,
  input  logic                        narrow_i,
  input  logic                        word_i,
  input  rm_e                         rm_i,
  input  mac_op_t                     mac_op_i,
  input  logic [data_width_p-1:0]     a_i,
  input  logic [data_width_p-1:0]     b_i,
  input  logic [data_width_p-1:0]     c_i,
  output logic                        v_o,
  output logic                        is_imul_o,
  output logic                        narrow_o,
  output logic                        word_o,
  output rm_e                         rm_o,
  output logic [2*data_width_p+1:0]   sum_o,
  output logic [data_width_p-1:0]     prod_lo_o
);

  // two guard bits above the product keep the sum exact for any operands
  localparam int sum_width_lp  = 2*data_width_p+2;
  localparam int prod_width_lp = 2*data_width_p;

  typedef logic signed [sum_width_lp-1:0] sum_t;

  logic signed [prod_width_lp-1:0] prod;
  sum_t                            prod_ext;
  sum_t                            addend;
  sum_t                            prod_term;
  sum_t                            addend_term;
  sum_t                            sum;

  always_comb
  begin
    prod     = $signed(a_i) * $signed(b_i);
    prod_ext = {{(sum_width_lp-prod_width_lp){prod[prod_width_lp-1]}}, prod};
    // align the addend with the binary point of the product
    addend = sum_t'($signed(c_i)) <<< frac_width_p;
  end

  always_comb
  begin
    prod_term   = mac_op_i[1] ? -prod_ext : prod_ext;
    addend_term = mac_op_i[0] ? -addend : addend;
    sum         = prod_term + addend_term;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      v_o <= 1'b0;
    else
      v_o <= v_i;
  end

  always_ff @(posedge clk_i)
  begin
    is_imul_o <= is_imul_i;
    narrow_o  <= narrow_i;
    word_o    <= word_i;
    rm_o      <= rm_i;
    sum_o     <= sum;
    // the low half of a product is the same for signed and unsigned operands
    prod_lo_o <= prod[data_width_p-1:0];
  end

endmodule

//--- logic/fxp_pipe_pkg.sv
package fxp_pipe_pkg;

  // operations accepted by the pipe
  // the fused ops follow the RISC-V sign semantics of fmadd and its relatives
  typedef enum logic [2:0]
  {
    fadd   = 3'd0,
    fsub   = 3'd1,
    fmul   = 3'd2,
    fmadd  = 3'd3,
    fmsub  = 3'd4,
    fnmsub = 3'd5,
    fnmadd = 3'd6,
    imul   = 3'd7
  } fu_op_e;

  // rounding mode codes as in the RISC-V frm field
  // codes 5 and 6 are reserved and are treated as rtz by the pipe
  typedef enum logic [2:0]
  {
    rne = 3'd0,
    rtz = 3'd1,
    rdn = 3'd2,
    rup = 3'd3,
    rmm = 3'd4,
    dyn = 3'd7
  } rm_e;

  // exception flags of a fused result
  // bit 1 is overflow, bit 0 is inexact
  typedef logic [1:0] fflags_t;

  // sign control of the multiply-add datapath
  //   enc | semantics
  //   0 0 :   (a x b) + c
  //   0 1 :   (a x b) - c
  //   1 0 : - (a x b) + c
  //   1 1 : - (a x b) - c
  typedef logic [1:0] mac_op_t;

endpackage

//--- logic/fxp_pipe_retime.sv
`timescale 1ns/10ps

module fxp_pipe_retime
#(
  parameter int width_p  = 32,
  parameter int stages_p = 1
)
(
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               v_i,
  input  logic [width_p-1:0] data_i,
  output logic               v_o,
  output logic [width_p-1:0] data_o
);

  if (stages_p == 0)
  begin : g_bypass
    assign v_o    = v_i;
    assign data_o = data_i;
  end
  else
  begin : g_chain
    logic [stages_p-1:0] v_r;
    logic [width_p-1:0]  data_r [stages_p];

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
        v_r <= '0;
      else
      begin
        v_r[0] <= v_i;
        for (int i = 1; i < stages_p; i++)
          v_r[i] <= v_r[i-1];
      end
    end

    always_ff @(posedge clk_i)
    begin
      data_r[0] <= data_i;
      for (int i = 1; i < stages_p; i++)
        data_r[i] <= data_r[i-1];
    end

    assign v_o    = v_r[stages_p-1];
    assign data_o = data_r[stages_p-1];
  end

endmodule

//--- logic/fxp_pipe_round.sv
`timescale 1ns/10ps

module fxp_pipe_round
  import fxp_pipe_pkg::*;
#(
  parameter int data_width_p = 32,
  parameter int frac_width_p = 16
)
(
  input  logic                      v_i,
  input  logic                      is_imul_i,
  input  logic                      narrow_i,
  input  logic                      word_i,
  input  rm_e                       rm_i,
  input  logic [2*data_width_p+1:0] sum_i,
  input  logic [data_width_p-1:0]   prod_lo_i,
  output logic                      fma_v_o,
  output logic [data_width_p-1:0]   fma_data_o,
  output fflags_t                   fma_fflags_o,
  output logic                      imul_v_o,
  output logic [data_width_p-1:0]   imul_data_o
);

  localparam int sum_width_lp  = 2*data_width_p+2;
  localparam int half_width_lp = data_width_p/2;

  typedef logic signed [sum_width_lp-1:0] sum_t;

  localparam sum_t one_lp      = sum_t'(1);
  localparam sum_t max_full_lp = (one_lp <<< (data_width_p-1)) - one_lp;
  localparam sum_t min_full_lp = -(one_lp <<< (data_width_p-1));
  localparam sum_t max_half_lp = (one_lp <<< (half_width_lp-1)) - one_lp;
  localparam sum_t min_half_lp = -(one_lp <<< (half_width_lp-1));

  // all dropped bits below the guard bit
  localparam logic [frac_width_p-1:0] sticky_mask_lp = '1 >> 1;

  logic [frac_width_p-1:0] dropped;
  logic                    guard;
  logic                    sticky;
  logic                    inexact;
  logic                    neg;
  logic                    round_up;
  logic                    ovf;
  sum_t                    shifted;
  sum_t                    rounded;
  sum_t                    hi_lim;
  sum_t                    lo_lim;

  always_comb
  begin
    // the arithmetic shift gives the floor of the exact value
    shifted = $signed(sum_i) >>> frac_width_p;
    dropped = sum_i[frac_width_p-1:0];
    guard   = dropped[frac_width_p-1];
    sticky  = |(dropped & sticky_mask_lp);
    inexact = guard | sticky;
    neg     = sum_i[sum_width_lp-1];

    // increment decision relative to the floor
    case (rm_i)
      rne:     round_up = guard & (sticky | shifted[0]);
      rdn:     round_up = 1'b0;
      rup:     round_up = inexact;
      rmm:     round_up = guard & (sticky | ~neg);
      default: round_up = neg & inexact;
    endcase

    rounded = shifted + sum_t'(round_up);
  end

  always_comb
  begin
    hi_lim = narrow_i ? max_half_lp : max_full_lp;
    lo_lim = narrow_i ? min_half_lp : min_full_lp;
    ovf    = (rounded > hi_lim) || (rounded < lo_lim);

    // a value in range already carries its sign above the half width
    if (rounded > hi_lim)
      fma_data_o = hi_lim[data_width_p-1:0];
    else if (rounded < lo_lim)
      fma_data_o = lo_lim[data_width_p-1:0];
    else
      fma_data_o = rounded[data_width_p-1:0];

    fma_fflags_o = ovf ? 2'b11 : {1'b0, inexact};
  end

  assign fma_v_o  = v_i & ~is_imul_i;
  assign imul_v_o = v_i & is_imul_i;

  // word results keep the lower half and extend its sign
  assign imul_data_o = word_i ?
    {{(data_width_p-half_width_lp){prod_lo_i[half_width_lp-1]}}, prod_lo_i[half_width_lp-1:0]} :
    prod_lo_i;

endmodule

//--- sources.f
+incdir+verification
logic/fxp_pipe_pkg.sv
logic/fxp_pipe_retime.sv
logic/fxp_pipe_decode.sv
logic/fxp_pipe_mul_add.sv
logic/fxp_pipe_round.sv
logic/fxp_pipe_fma.sv
verification/fxp_pipe_tb.sv

//--- verification/fxp_pipe_model.svh
`ifndef FXP_PIPE_MODEL_SVH
`define FXP_PIPE_MODEL_SVH

// 32-bit Fibonacci LFSR with taps 32 22 2 1 that steps once per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  logic        fb;
  r = '0;
  for (int i = 0; i < n; i++)
  begin
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    r          = {r[30:0], fb};
  end
  return r;
endfunction

// random signed operand whose magnitude shrinks with the shift
function automatic logic [data_width_lp-1:0] rand_operand(input int min_shift);
  logic signed [data_width_lp-1:0] raw;
  int                              sh;
  raw = rand_bits(data_width_lp);
  sh  = min_shift + int'(rand_bits(3));
  return raw >>> sh;
endfunction

// dyn takes the frm code, and every code above rmm rounds toward zero
function automatic logic [2:0] resolve_rm(input logic [2:0] mode, input logic [2:0] frm);
  logic [2:0] m;
  m = (mode == 3'd7) ? frm : mode;
  return (m > 3'd4) ? 3'd1 : m;
endfunction

function automatic void model_fma(input fu_op_e op, input logic [2:0] mode, input logic nar,
  input logic [data_width_lp-1:0] rs1_v, input logic [data_width_lp-1:0] rs2_v,
  input logic [data_width_lp-1:0] rs3_v, output logic [data_width_lp-1:0] res,
  output logic [1:0] flags);
  wide_t x;
  wide_t y;
  wide_t z;
  wide_t scale;
  wide_t exact;
  wide_t fl;
  wide_t rem;
  wide_t half;
  wide_t q;
  wide_t lim_hi;
  wide_t lim_lo;
  logic  up;
  x     = $signed(rs1_v);
  y     = $signed(rs2_v);
  z     = $signed(rs3_v);
  scale = wide_t'(1) <<< frac_width_lp;
  half  = scale >>> 1;
  // exact value scaled by 2^frac, so the product needs no shift
  case (op)
    fadd:    exact = (x + y) * scale;
    fsub:    exact = (x - y) * scale;
    fmul:    exact = x * y;
    fmadd:   exact = x * y + z * scale;
    fmsub:   exact = x * y - z * scale;
    fnmsub:  exact = z * scale - x * y;
    default: exact = -(x * y) - z * scale;
  endcase
  fl  = exact >>> frac_width_lp;
  rem = exact - fl * scale;
  case (mode)
    rne:     up = (rem > half) || (rem == half && fl[0]);
    rtz:     up = (exact < 0) && (rem != 0);
    rdn:     up = 1'b0;
    rup:     up = (rem != 0);
    default: up = (rem > half) || (rem == half && exact >= 0);
  endcase
  if (up)
    q = fl + 1;
  else
    q = fl;
  if (nar)
    lim_hi = (wide_t'(1) <<< (data_width_lp/2 - 1)) - 1;
  else
    lim_hi = (wide_t'(1) <<< (data_width_lp - 1)) - 1;
  lim_lo = -lim_hi - 1;
  if (q > lim_hi)
  begin
    res   = lim_hi[data_width_lp-1:0];
    flags = 2'b11;
  end
  else if (q < lim_lo)
  begin
    res   = lim_lo[data_width_lp-1:0];
    flags = 2'b11;
  end
  else
  begin
    res   = q[data_width_lp-1:0];
    flags = {1'b0, rem != 0};
  end
endfunction

function automatic logic [data_width_lp-1:0] model_imul(input logic wrd,
  input logic [data_width_lp-1:0] rs1_v, input logic [data_width_lp-1:0] rs2_v);
  wide_t                    x;
  wide_t                    y;
  wide_t                    p;
  logic [data_width_lp-1:0] lo;
  x  = $signed(rs1_v);
  y  = $signed(rs2_v);
  p  = x * y;
  lo = p[data_width_lp-1:0];
  if (wrd)
    return {{(data_width_lp/2){lo[data_width_lp/2-1]}}, lo[data_width_lp/2-1:0]};
  return lo;
endfunction

// queue the expected result of an accepted operation with its due cycle
task automatic expect_op(input fu_op_e op, input rm_e mode, input rm_e frm, input logic nar,
  input logic wrd, input logic [data_width_lp-1:0] a, input logic [data_width_lp-1:0] b,
  input logic [data_width_lp-1:0] c);
  logic [data_width_lp-1:0] res;
  logic [1:0]               flags;
  if (op == imul)
  begin
    imul_due_q.push_back(cyc + imul_latency_lp);
    imul_data_q.push_back(model_imul(wrd, a, b));
  end
  else
  begin
    model_fma(op, resolve_rm(mode, frm), nar, a, b, c, res, flags);
    fma_due_q.push_back(cyc + fma_latency_lp);
    fma_data_q.push_back(res);
    fma_flags_q.push_back(flags);
    fma_op_q.push_back(op);
  end
endtask

task automatic check_fma_port();
  int                       due;
  fu_op_e                   op;
  logic [data_width_lp-1:0] exp_data;
  logic [1:0]               exp_flags;
  if (fma_v)
  begin
    assert (fma_due_q.size() > 0) else
    begin
      $display("unexpected fma result at cycle %0d with nothing pending", cyc);
      err_cnt++;
    end
    if (fma_due_q.size() > 0)
    begin
      due       = fma_due_q.pop_front();
      op        = fma_op_q.pop_front();
      exp_data  = fma_data_q.pop_front();
      exp_flags = fma_flags_q.pop_front();
      chk_cnt++;
      assert (cyc == due) else
      begin
        $display("ERR %0t: %s result at cycle %0d, due at cycle %0d", $time, op.name(), cyc, due);
        err_cnt++;
      end
      assert (fma_data === exp_data && fma_fflags === exp_flags) else
      begin
        $display("ERR %0t: %s gave %h flags %b, expected %h flags %b", $time, op.name(),
          fma_data, fma_fflags, exp_data, exp_flags);
        err_cnt++;
      end
    end
  end
  else
  begin
    assert (fma_due_q.size() == 0 || fma_due_q[0] > cyc) else
    begin
      $display("fma result due at cycle %0d never arrived", fma_due_q[0]);
      due = fma_due_q.pop_front();
      op  = fma_op_q.pop_front();
      exp_data  = fma_data_q.pop_front();
      exp_flags = fma_flags_q.pop_front();
      err_cnt++;
    end
  end
endtask

task automatic check_imul_port();
  int                       due;
  logic [data_width_lp-1:0] exp_data;
  if (imul_v)
  begin
    assert (imul_due_q.size() > 0) else
    begin
      $display("unexpected imul result at cycle %0d with nothing pending", cyc);
      err_cnt++;
    end
    if (imul_due_q.size() > 0)
    begin
      due      = imul_due_q.pop_front();
      exp_data = imul_data_q.pop_front();
      chk_cnt++;
      assert (cyc == due && imul_data === exp_data) else
      begin
        $display("ERR %0t: imul gave %h at cycle %0d, expected %h at cycle %0d", $time,
          imul_data, cyc, exp_data, due);
        err_cnt++;
      end
    end
  end
  else
  begin
    assert (imul_due_q.size() == 0 || imul_due_q[0] > cyc) else
    begin
      $display("imul result due at cycle %0d never arrived", imul_due_q[0]);
      due      = imul_due_q.pop_front();
      exp_data = imul_data_q.pop_front();
      err_cnt++;
    end
  end
endtask

`endif

//--- verification/fxp_pipe_tb.sv
`timescale 1ns/10ps

module fxp_pipe_tb
  import fxp_pipe_pkg::*;
();

  localparam int data_width_lp   = 32;
  localparam int frac_width_lp   = 16;
  localparam int fma_latency_lp  = 4;
  localparam int imul_latency_lp = 3;

  // stimulus length of each test, and the idle cycles that drain the pipe after it
  localparam int reset_cycles_lp = 10;
  localparam int op_cycles_lp    = 140 + 180 + 62 + 40 + 120;
  localparam int drain_cycles_lp = 5 * (fma_latency_lp + 4);
  localparam int stim_cycles_lp  = reset_cycles_lp + op_cycles_lp + drain_cycles_lp;
  localparam int timeout_lp      = 2 * stim_cycles_lp + fma_latency_lp + imul_latency_lp;

  // 0.5 in the fixed point format makes ties from odd operands
  localparam logic [data_width_lp-1:0] half_lp = 1 << (frac_width_lp - 1);

  typedef logic signed [127:0] wide_t;

  logic                     clk = 1'b0;
  logic                     arst_n;
  logic                     in_v;
  logic                     in_poison;
  fu_op_e                   fu_op;
  rm_e                      rm;
  rm_e                      frm_dyn;
  logic                     narrow;
  logic                     word;
  logic [data_width_lp-1:0] rs1;
  logic [data_width_lp-1:0] rs2;
  logic [data_width_lp-1:0] rs3;
  logic                     fma_v;
  logic [data_width_lp-1:0] fma_data;
  fflags_t                  fma_fflags;
  logic                     imul_v;
  logic [data_width_lp-1:0] imul_data;

  int                       cyc = 0;
  int                       err_cnt = 0;
  int                       chk_cnt = 0;
  int                       test_cnt = 0;
  logic [31:0]              lfsr_state = 32'hf7a6;

  int                       fma_due_q[$];
  fu_op_e                   fma_op_q[$];
  logic [data_width_lp-1:0] fma_data_q[$];
  logic [1:0]               fma_flags_q[$];
  int                       imul_due_q[$];
  logic [data_width_lp-1:0] imul_data_q[$];

  `include "fxp_pipe_model.svh"

  fxp_pipe_fma
  #(
    .data_width_p(data_width_lp),
    .frac_width_p(frac_width_lp),
    .fma_latency_p(fma_latency_lp),
    .imul_latency_p(imul_latency_lp)
  )
  fxp_pipe_fma_i
  (
    .clk_i(clk), .arst_n_i(arst_n), .v_i(in_v), .poison_i(in_poison),
    .fu_op_i(fu_op), .rm_i(rm), .frm_dyn_i(frm_dyn), .narrow_i(narrow), .word_i(word),
    .rs1_i(rs1), .rs2_i(rs2), .rs3_i(rs3),
    .fma_v_o(fma_v), .fma_data_o(fma_data), .fma_fflags_o(fma_fflags),
    .imul_v_o(imul_v), .imul_data_o(imul_data)
  );

  initial
  begin
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
  begin
    if (cyc >= timeout_lp)
    begin
      $display("timeout: run stopped after %0d cycles with results still pending", cyc);
      $display("** FAIL **");
      $finish;
    end
    else
      cyc <= cyc + 1;
  end

  // outputs are sampled at the falling edge between two driving edges
  always @(negedge clk)
  begin
    if (!arst_n)
    begin
      assert (!fma_v && !imul_v) else
      begin
        $display("an output valid was high during reset at cycle %0d", cyc);
        err_cnt++;
      end
    end
    else
    begin
      check_fma_port();
      check_imul_port();
    end
  end

  task automatic drive_op(input fu_op_e op, input rm_e mode, input rm_e frm, input logic nar,
    input logic wrd, input logic [data_width_lp-1:0] a, input logic [data_width_lp-1:0] b,
    input logic [data_width_lp-1:0] c, input logic valid, input logic psn);
    @(posedge clk);
    #2;
    in_v      = valid;
    in_poison = psn;
    fu_op     = op;
    rm        = mode;
    frm_dyn   = frm;
    narrow    = nar;
    word      = wrd;
    rs1       = a;
    rs2       = b;
    rs3       = c;
    if (valid && !psn)
      expect_op(op, mode, frm, nar, wrd, a, b, c);
  endtask

  task automatic drive_random(input fu_op_e op, input rm_e mode, input rm_e frm, input logic nar,
    input logic wrd, input int min_shift, input logic valid, input logic psn);
    logic [data_width_lp-1:0] a;
    logic [data_width_lp-1:0] b;
    logic [data_width_lp-1:0] c;
    a = rand_operand(min_shift);
    b = rand_operand(min_shift);
    c = rand_operand(min_shift);
    drive_op(op, mode, frm, nar, wrd, a, b, c, valid, psn);
  endtask

  function automatic fu_op_e rand_fused_op();
    logic [2:0] k;
    k = rand_bits(3);
    if (k == 3'd7)
      k = 3'd3;
    return fu_op_e'(k);
  endfunction

  // drop the valid, let the queues drain and report the test
  task automatic finish_test(input string name, input int err_start);
    @(posedge clk);
    #2;
    in_v = 1'b0;
    while (fma_due_q.size() > 0 || imul_due_q.size() > 0)
      @(posedge clk);
    repeat (2) @(posedge clk);
    test_cnt++;
    $display("test %0d %s: done, %0d errors", test_cnt, name, err_cnt - err_start);
  endtask

  initial
  begin
    logic [data_width_lp-1:0] a;
    logic [data_width_lp-1:0] b;
    logic [2:0]               mcode;
    logic [2:0]               fcode;
    int                       err_start;
    arst_n    = 1'b0;
    in_v      = 1'b0;
    in_poison = 1'b0;
    fu_op     = fadd;
    rm        = rne;
    frm_dyn   = rne;
    narrow    = 1'b0;
    word      = 1'b0;
    rs1       = '0;
    rs2       = '0;
    rs3       = '0;
    repeat (reset_cycles_lp) @(posedge clk);
    #2;
    arst_n = 1'b1;

    err_start = err_cnt;
    for (int k = 0; k < 7; k++)
      for (int n = 0; n < 20; n++)
        drive_random(fu_op_e'(k), rne, rne, 1'b0, 1'b0, 8, 1'b1, 1'b0);
    finish_test("fused ops", err_start);

    // static codes 0 to 6 first, then dyn with every frm value
    err_start = err_cnt;
    for (int m = 0; m < 15; m++)
    begin
      mcode = (m < 7) ? m : 3'd7;
      fcode = (m < 7) ? rand_bits(3) : m - 7;
      for (int n = 0; n < 8; n++)
        drive_random(rand_fused_op(), rm_e'(mcode), rm_e'(fcode), 1'b0, 1'b0, 8, 1'b1, 1'b0);
      for (int n = 0; n < 4; n++)
      begin
        a = rand_operand(8) | 1;
        drive_op(fmul, rm_e'(mcode), rm_e'(fcode), 1'b0, 1'b0, a, half_lp, '0, 1'b1, 1'b0);
      end
    end
    finish_test("rounding modes", err_start);

    err_start = err_cnt;
    drive_op(fmul, rne, rne, 1'b0, 1'b0, 32'h8000_0000, 32'h8000_0000, '0, 1'b1, 1'b0);
    drive_op(fmadd, rup, rne, 1'b0, 1'b0, 32'h7fff_ffff, 32'h8000_0000, 32'h8000_0000,
      1'b1, 1'b0);
    for (int n = 0; n < 30; n++)
      drive_random(rand_fused_op(), rm_e'(rand_bits(3)), rm_e'(rand_bits(3)), 1'b0, 1'b0, 0,
        1'b1, 1'b0);
    for (int n = 0; n < 30; n++)
      drive_random(rand_fused_op(), rm_e'(rand_bits(3)), rm_e'(rand_bits(3)), 1'b1, 1'b0, 12,
        1'b1, 1'b0);
    finish_test("saturation and narrow", err_start);

    err_start = err_cnt;
    for (int n = 0; n < 40; n++)
    begin
      a = rand_bits(data_width_lp);
      b = rand_bits(data_width_lp);
      drive_op(imul, rne, rne, 1'b0, rand_bits(1), a, b, rand_operand(0), 1'b1, 1'b0);
    end
    finish_test("imul", err_start);

    // mixed traffic with gaps and poisoned slots lets results meet on both ports
    err_start = err_cnt;
    for (int n = 0; n < 120; n++)
      drive_random(fu_op_e'(rand_bits(3)), rm_e'(rand_bits(3)), rm_e'(rand_bits(3)),
        rand_bits(1), rand_bits(1), 8, rand_bits(2) != 0, rand_bits(3) == 0);
    finish_test("timing and filtering", err_start);

    $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0)
    begin
      $display("** PASS **");
    end
    else
    begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
